//--- soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// on-chip RAM, 32-bit words
`define RAM_BASE                (64'h0000_0000_8000_0000)
`define RAM_WORDS               (1024)

// machine timer
`define MTIME_ADDR              (64'h0000_0000_0200_BFF8)
`define MTIMECMP_ADDR           (64'h0000_0000_0200_4000)
`define MTIMECMP_RESET          (64'h0000_0000_8000_0000)  // above mtime after reset

// PLIC, two contexts (hart0 M and hart0 S)
`define PLIC_BASE               (64'h0000_0000_0C00_0000)  // priority array, 4 bytes per id
`define PLIC_PENDING            (`PLIC_BASE + 64'h1000)
`define PLIC_ENABLE             (`PLIC_BASE + 64'h2000)      // context 0
`define PLIC_CTX_ENABLE_STRIDE  (64'h80)
`define PLIC_THRESHOLD          (`PLIC_BASE + 64'h20_0000)   // context 0
`define PLIC_CLAIM              (`PLIC_BASE + 64'h20_0004)   // context 0
`define PLIC_CTX_STRIDE         (64'h1000)

// ids 1..PLIC_SOURCES, id 0 means none
`define PLIC_SOURCES            (7)
`define PLIC_PRIO_BITS          (3)

`endif

//--- bus_pkg.sv
package bus_pkg;

    // load/store width, stores only use lb..ld (sb, sh, sw, sd)
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } ls_type_e;

    // cpu side request, held stable until done rises
    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        ls_type_e    ls_type;
        logic        write;
    } bus_req_t;

    // target answer, ack is a single cycle pulse
    typedef struct packed {
        logic [63:0] rdata;
        logic        ack;
    } bus_rsp_t;

endpackage

//--- periph_pkg.sv
package periph_pkg;

    // which block serves the current access
    typedef enum logic [1:0] {
        tgt_none,    // unmapped, acked by the fabric
        tgt_ram,
        tgt_timer,
        tgt_plic
    } target_e;

    // interrupt lines towards the hart
    typedef struct packed {
        logic meip;  // machine external
        logic seip;  // supervisor external
        logic mtip;  // machine timer
    } irq_lines_t;

endpackage

//--- bus_fabric.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module bus_fabric (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              read_enable,
    input  logic              write_enable,
    input  bus_pkg::bus_req_t cmd,
    input  bus_pkg::bus_rsp_t ram_rsp,
    input  bus_pkg::bus_rsp_t timer_rsp,
    input  bus_pkg::bus_rsp_t plic_rsp,
    output logic              read_done,
    output logic              write_done,
    output logic [63:0]       rdata,
    output bus_pkg::bus_req_t tgt_req,
    output logic              ram_stb,
    output logic              timer_stb,
    output logic              plic_stb
);
    import bus_pkg::*;
    import periph_pkg::*;

    target_e  tgt_dec;   // decode of the incoming address
    target_e  tgt_q;     // target of the access in flight
    logic     accept;
    logic     none_stb;
    logic     none_ack;
    bus_rsp_t sel_rsp;

    // requests while busy are dropped
    assign accept = (read_enable || write_enable) && read_done && write_done;

    always_comb begin
        if (cmd.addr >= `RAM_BASE && cmd.addr < `RAM_BASE + 4 * `RAM_WORDS)
            tgt_dec = tgt_ram;
        else if (cmd.addr == `MTIME_ADDR || cmd.addr == `MTIMECMP_ADDR)
            tgt_dec = tgt_timer;
        else if (cmd.addr >= `PLIC_BASE && cmd.addr < `PLIC_THRESHOLD + 2 * `PLIC_CTX_STRIDE)
            tgt_dec = tgt_plic;
        else
            tgt_dec = tgt_none;
    end

    always_comb begin
        case (tgt_q)
            tgt_ram:   sel_rsp = ram_rsp;
            tgt_timer: sel_rsp = timer_rsp;
            tgt_plic:  sel_rsp = plic_rsp;
            default:   sel_rsp = '{rdata: 64'd0, ack: none_ack};  // unmapped reads as zero
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done  <= 1'b1;
            write_done <= 1'b1;
            tgt_q      <= tgt_none;
            ram_stb    <= 1'b0;
            timer_stb  <= 1'b0;
            plic_stb   <= 1'b0;
            none_stb   <= 1'b0;
            none_ack   <= 1'b0;
        end else begin
            ram_stb   <= accept && tgt_dec == tgt_ram;
            timer_stb <= accept && tgt_dec == tgt_timer;
            plic_stb  <= accept && tgt_dec == tgt_plic;
            none_stb  <= accept && tgt_dec == tgt_none;
            none_ack  <= none_stb;                     // self ack one cycle later
            if (accept) begin
                tgt_q <= tgt_dec;
                if (read_enable) read_done <= 1'b0;
                else write_done <= 1'b0;
            end else if (sel_rsp.ack) begin
                if (tgt_req.write) write_done <= 1'b1;
                else read_done <= 1'b1;
            end
        end
    end

    // request payload and returned data
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            tgt_req       <= cmd;
            tgt_req.write <= write_enable;  // direction comes from the enable pulse
        end
        if (sel_rsp.ack && !tgt_req.write) rdata <= sel_rsp.rdata;
    end

    a_no_req_busy: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (read_enable || write_enable) |-> (read_done && write_done))
        else $error("bus request while an access is in flight");

    a_one_dir: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(read_enable && write_enable))
        else $error("read_enable and write_enable both high");

endmodule

//--- ram_port.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module ram_port (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              stb,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp
);
    import bus_pkg::*;

    localparam int AW = $clog2(`RAM_WORDS);

    typedef enum logic {st_idle, st_high} step_e;  // st_high = second word of ld/sd

    logic [31:0]   mem [`RAM_WORDS];
    step_e         step;
    logic [AW-1:0] idx;
    logic [1:0]    lane;
    logic          dword;
    logic [3:0]    be;
    logic [31:0]   wword;     // store data moved into its lane
    logic [63:0]   rdata_q;
    logic          ack_q;

    assign idx   = req.addr[AW+1:2];
    assign lane  = req.addr[1:0];
    assign dword = (req.ls_type == ld);

    // pick the addressed lane and extend it
    function automatic logic [63:0] load_ext(input logic [31:0] word, input logic [1:0] off,
                                             input ls_type_e t);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (t)
            lb:      return {{56{sh[7]}}, sh[7:0]};
            lbu:     return {56'd0, sh[7:0]};
            lh:      return {{48{sh[15]}}, sh[15:0]};
            lhu:     return {48'd0, sh[15:0]};
            lw:      return {{32{sh[31]}}, sh};
            default: return {32'd0, sh};       // lwu
        endcase
    endfunction

    always_comb begin
        case (req.ls_type)
            lb:      be = 4'b0001 << lane;
            lh:      be = 4'b0011 << lane;
            default: be = 4'b1111;
        endcase
        wword = req.wdata[31:0] << (8 * lane);
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            step  <= st_idle;
            ack_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (step)
                st_idle: begin
                    if (stb && dword) step <= st_high;
                    else if (stb) ack_q <= 1'b1;
                end
                default: begin
                    step  <= st_idle;
                    ack_q <= 1'b1;      // ack after the high word
                end
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (step == st_high) begin
            if (req.write) mem[idx + 1'b1] <= req.wdata[63:32];
            else rdata_q[63:32] <= mem[idx + 1'b1];
        end else if (stb) begin
            if (req.write) begin
                for (int b = 0; b < 4; b++)
                    if (be[b]) mem[idx][8*b +: 8] <= wword[8*b +: 8];
            end else if (dword) begin
                rdata_q[31:0] <= mem[idx];   // low word first
            end else begin
                rdata_q <= load_ext(mem[idx], lane, req.ls_type);
            end
        end
    end

    assign rsp = '{rdata: rdata_q, ack: ack_q};

    a_half_align: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (stb && (req.ls_type inside {lh, lhu})) |-> req.addr[0] == 1'b0);
    a_word_align: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (stb && (req.ls_type inside {lw, lwu})) |-> req.addr[1:0] == 2'b00);
    a_dword_align: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (stb && dword) |-> req.addr[2:0] == 3'b000);

endmodule

//--- machine_timer.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module machine_timer (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              stb,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp,
    output logic              mtip
);
    logic [63:0] mtime;      // free running, read only
    logic [63:0] mtimecmp;
    logic [63:0] rdata_q;
    logic        ack_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtime    <= '0;
            mtimecmp <= `MTIMECMP_RESET;
            ack_q    <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            ack_q <= stb;              // writes to mtime are acked and dropped
            if (stb && req.write && req.addr == `MTIMECMP_ADDR) mtimecmp <= req.wdata;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (stb) rdata_q <= (req.addr == `MTIME_ADDR) ? mtime : mtimecmp;
    end

    assign mtip = (mtime >= mtimecmp);
    assign rsp  = '{rdata: rdata_q, ack: ack_q};

endmodule

//--- plic_unit.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module plic_unit (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  logic                     stb,
    input  bus_pkg::bus_req_t        req,
    input  logic [`PLIC_SOURCES-1:0] irq_src,
    output bus_pkg::bus_rsp_t        rsp,
    output logic                     meip,
    output logic                     seip
);
    localparam int NS = `PLIC_SOURCES;
    localparam int PW = `PLIC_PRIO_BITS;
    localparam int IW = $clog2(NS + 1);

    logic [PW-1:0] prio [1:NS];
    logic [NS:1]   pending;
    logic [NS:1]   enable [2];
    logic [PW-1:0] threshold [2];
    logic [IW-1:0] claim_id [2];
    logic [NS-1:0] src_q;
    logic [NS:1]   rise;
    logic [NS:1]   claim_clr;
    logic [IW-1:0] prio_id;
    logic          prio_hit;
    logic [63:0]   rd_val;
    logic [63:0]   rdata_q;
    logic          ack_q;

    assign rise     = irq_src & ~src_q;          // source i is id i+1
    assign prio_id  = req.addr[IW+1:2];
    assign prio_hit = req.addr >= `PLIC_BASE && req.addr < `PLIC_BASE + 4 * (NS + 1)
                      && prio_id != '0;

    // lowest eligible id wins, scan from the top down
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            claim_id[c] = '0;
            for (int id = NS; id >= 1; id--)
                if (pending[id] && enable[c][id] && prio[id] > threshold[c])
                    claim_id[c] = IW'(id);
        end
    end

    assign meip = (claim_id[0] != '0);
    assign seip = (claim_id[1] != '0);

    always_comb begin
        rd_val    = '0;
        claim_clr = '0;
        if (prio_hit) rd_val = 64'(prio[prio_id]);
        if (req.addr == `PLIC_PENDING) rd_val = 64'({pending, 1'b0});
        for (int c = 0; c < 2; c++) begin
            if (req.addr == `PLIC_ENABLE + c * `PLIC_CTX_ENABLE_STRIDE)
                rd_val = 64'({enable[c], 1'b0});
            if (req.addr == `PLIC_THRESHOLD + c * `PLIC_CTX_STRIDE)
                rd_val = 64'(threshold[c]);
            if (req.addr == `PLIC_CLAIM + c * `PLIC_CTX_STRIDE) begin
                rd_val = 64'(claim_id[c]);
                if (stb && !req.write && claim_id[c] != '0)
                    claim_clr[claim_id[c]] = 1'b1;  // claim read completes the claim
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int id = 1; id <= NS; id++) prio[id] <= '0;
            pending   <= '0;
            enable    <= '{default: '0};
            threshold <= '{default: '0};
            src_q     <= '0;
            ack_q     <= 1'b0;
        end else begin
            src_q   <= irq_src;
            ack_q   <= stb;
            pending <= (pending & ~claim_clr) | rise;  // a fresh edge beats the clear
            if (stb && req.write) begin
                if (prio_hit) prio[prio_id] <= req.wdata[PW-1:0];
                for (int c = 0; c < 2; c++) begin
                    if (req.addr == `PLIC_ENABLE + c * `PLIC_CTX_ENABLE_STRIDE)
                        enable[c] <= req.wdata[NS:1];
                    if (req.addr == `PLIC_THRESHOLD + c * `PLIC_CTX_STRIDE)
                        threshold[c] <= req.wdata[PW-1:0];
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (stb) rdata_q <= rd_val;
    end

    assign rsp = '{rdata: rdata_q, ack: ack_q};

endmodule

//--- soc_periph_top.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_periph_top (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  logic                     read_enable,
    input  logic                     write_enable,
    input  bus_pkg::bus_req_t        cmd,
    input  logic [`PLIC_SOURCES-1:0] irq_src,
    output logic                     read_done,
    output logic                     write_done,
    output logic [63:0]              rdata,
    output periph_pkg::irq_lines_t   irq
);
    import bus_pkg::*;

    bus_req_t tgt_req;    // registered request, shared by all targets
    bus_rsp_t ram_rsp;
    bus_rsp_t timer_rsp;
    bus_rsp_t plic_rsp;
    logic     ram_stb;
    logic     timer_stb;
    logic     plic_stb;
    logic     meip;
    logic     seip;
    logic     mtip;

    bus_fabric u_fabric (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0),
        .read_enable(read_enable), .write_enable(write_enable), .cmd(cmd),
        .ram_rsp(ram_rsp), .timer_rsp(timer_rsp), .plic_rsp(plic_rsp),
        .read_done(read_done), .write_done(write_done), .rdata(rdata),
        .tgt_req(tgt_req), .ram_stb(ram_stb), .timer_stb(timer_stb), .plic_stb(plic_stb)
    );

    ram_port u_ram (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .stb(ram_stb), .req(tgt_req), .rsp(ram_rsp)
    );

    machine_timer u_timer (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .stb(timer_stb), .req(tgt_req),
        .rsp(timer_rsp), .mtip(mtip)
    );

    plic_unit u_plic (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .stb(plic_stb), .req(tgt_req),
        .irq_src(irq_src), .rsp(plic_rsp), .meip(meip), .seip(seip)
    );

    assign irq = '{meip: meip, seip: seip, mtip: mtip};

endmodule

//--- tb_soc.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module tb_soc;
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int CLK_PERIOD        = 4;
    localparam int NS                = `PLIC_SOURCES;
    localparam int PW                = `PLIC_PRIO_BITS;
    localparam int NUM_TESTS         = 5;
    localparam int WORST_LAT         = 3;     // ld and sd
    localparam int ACCESSES_PER_TEST = 200;
    localparam int MARGIN            = 4;
    // each access costs its latency plus about three handshake cycles
    localparam int TIMEOUT_CYCLES    = NUM_TESTS * ACCESSES_PER_TEST * (WORST_LAT + 3) * MARGIN;
    localparam int TIMER_LEAD        = 30;    // how far mtimecmp is set ahead of mtime
    localparam logic [63:0] UNMAPPED_ADDR = 64'h0000_0000_1000_0000;

    logic              CLOCK_50;
    logic              KEY0;
    logic              read_enable;
    logic              write_enable;
    bus_req_t          cmd;
    logic [NS-1:0]     irq_src;
    logic              read_done;
    logic              write_done;
    logic [63:0]       rdata;
    irq_lines_t        irq;

    // reference model state
    logic [7:0]        ram_ref [4 * `RAM_WORDS];   // byte mirror of the RAM
    logic [PW-1:0]     p_prio [1:NS];
    logic [NS:1]       p_pend;
    logic [NS:1]       p_en [2];
    logic [PW-1:0]     p_thr [2];

    int cyc            = 0;
    int err_count      = 0;
    int check_count    = 0;
    int tests_run      = 0;
    int tests_ok       = 0;
    int test_err_start = 0;
    int req_cyc;
    string       name_q [$];
    logic [63:0] exp_q [$];
    logic [63:0] act_q [$];
    time         time_q [$];

    soc_periph_top dut (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0),
        .read_enable(read_enable), .write_enable(write_enable), .cmd(cmd),
        .irq_src(irq_src), .read_done(read_done), .write_done(write_done),
        .rdata(rdata), .irq(irq)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
    end

    always @(negedge CLOCK_50) cyc <= cyc + 1;  // read on rising edges only

    // compare process drains the queued results
    always @(negedge CLOCK_50) begin
        while (name_q.size() > 0) begin
            if (exp_q[0] !== act_q[0]) begin
                $display("FAILED t=%0t %s expected %h actual %h",
                         time_q[0], name_q[0], exp_q[0], act_q[0]);
                err_count++;
            end
            void'(name_q.pop_front());
            void'(exp_q.pop_front());
            void'(act_q.pop_front());
            void'(time_q.pop_front());
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("run did not finish within %0d cycles, a test is stuck", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
        time_q.push_back($time);
        check_count++;
    endtask

    // one access returning data and the cycles from request edge to done
    task automatic bus_access(input logic wr, input logic [63:0] addr, input logic [63:0] wdata,
                              input ls_type_e t, output logic [63:0] data, output int lat);
        bus_req_t c;
        c = '{addr: addr, wdata: wdata, ls_type: t, write: wr};
        @(posedge CLOCK_50);
        cmd <= c;
        if (wr) write_enable <= 1'b1;
        else read_enable <= 1'b1;
        @(posedge CLOCK_50);                  // request edge
        read_enable  <= 1'b0;
        write_enable <= 1'b0;
        req_cyc = cyc;
        lat = 0;
        @(negedge CLOCK_50);
        if (wr) expect_eq("write_done fall", 64'd0, 64'(write_done));
        else expect_eq("read_done fall", 64'd0, 64'(read_done));
        do begin
            @(negedge CLOCK_50);
            lat++;
        end while (!(wr ? write_done : read_done));
        data = rdata;
        if (wr) expect_eq("read_done", 64'd1, 64'(read_done));   // the other flag stays up
        else expect_eq("write_done", 64'd1, 64'(write_done));
    endtask

    task automatic do_write(input logic [63:0] addr, input logic [63:0] wdata,
                            input ls_type_e t, output int lat);
        logic [63:0] ignored;
        bus_access(1'b1, addr, wdata, t, ignored, lat);
    endtask

    task automatic do_read(input logic [63:0] addr, input ls_type_e t,
                           output logic [63:0] data, output int lat);
        bus_access(1'b0, addr, 64'd0, t, data, lat);
    endtask

    function automatic int size_bytes(input ls_type_e t);
        case (t)
            lb, lbu: return 1;
            lh, lhu: return 2;
            lw, lwu: return 4;
            default: return 8;
        endcase
    endfunction

    // expected load from little endian bytes with sign fill
    function automatic logic [63:0] ref_load(input logic [63:0] addr, input ls_type_e t);
        logic [63:0] val;
        int n;
        int base;
        val  = '0;
        n    = size_bytes(t);
        base = int'(addr - `RAM_BASE);
        for (int i = 0; i < n; i++) val[8*i +: 8] = ram_ref[base + i];
        if (t inside {lb, lh, lw} && val[8*n-1])
            val = val | ~((64'd1 << (8 * n)) - 64'd1);
        return val;
    endfunction

    function automatic void ref_store(input logic [63:0] addr, input logic [63:0] wdata,
                                      input ls_type_e t);
        int base;
        base = int'(addr - `RAM_BASE);
        for (int i = 0; i < size_bytes(t); i++) ram_ref[base + i] = wdata[8*i +: 8];
    endfunction

    // first eligible id counting up or 0 when none
    function automatic int ref_claim(input int c);
        for (int id = 1; id <= NS; id++)
            if (p_pend[id] && p_en[c][id] && p_prio[id] > p_thr[c]) return id;
        return 0;
    endfunction

    task automatic end_test(input string name);
        int errs;
        repeat (2) @(negedge CLOCK_50);       // compare process catches up
        errs = err_count - test_err_start;
        test_err_start = err_count;
        tests_run++;
        if (errs == 0) tests_ok++;
        $display("test %0d (%s) done with %0d errors", tests_run, name, errs);
    endtask

    task automatic test_reset();
        logic [63:0] data;
        int lat;
        @(negedge CLOCK_50);
        expect_eq("read_done", 64'd1, 64'(read_done));
        expect_eq("write_done", 64'd1, 64'(write_done));
        expect_eq("irq", 64'd0, 64'(irq));
        do_read(`MTIMECMP_ADDR, ld, data, lat);
        expect_eq("mtimecmp", `MTIMECMP_RESET, data);
        end_test("reset state");
    endtask

    task automatic test_ram_widths();
        logic [63:0] base;
        logic [63:0] data;
        logic [63:0] wdata;
        ls_type_e t;
        int off;
        int lat;
        base = `RAM_BASE + 64'(($urandom() % 16) * 256);  // 64-word region
        for (int w = 0; w < 64; w++) begin
            wdata = {32'd0, $urandom()};
            do_write(base + 64'(4 * w), wdata, lw, lat);
            ref_store(base + 64'(4 * w), wdata, lw);
        end
        for (int i = 0; i < 48; i++) begin
            t     = ls_type_e'(3'(i % 4));    // sb, sh, sw, sd in turn
            off   = int'($urandom() % 256) & ~(size_bytes(t) - 1);
            wdata = {$urandom(), $urandom()};
            do_write(base + 64'(off), wdata, t, lat);
            ref_store(base + 64'(off), wdata, t);
        end
        for (int i = 0; i < 56; i++) begin
            t   = ls_type_e'(3'(i % 7));      // all seven load types
            off = int'($urandom() % 256) & ~(size_bytes(t) - 1);
            do_read(base + 64'(off), t, data, lat);
            expect_eq("rdata", ref_load(base + 64'(off), t), data);
        end
        end_test("ram width round trip");
    endtask

    task automatic test_latency();
        logic [63:0] data;
        logic [63:0] wdata;
        int lat;
        wdata = {$urandom(), $urandom()};
        do_write(`RAM_BASE + 64'h800, wdata, ld, lat);
        ref_store(`RAM_BASE + 64'h800, wdata, ld);
        expect_eq("latency sd", 64'd3, 64'(lat));
        do_read(`RAM_BASE + 64'h800, ld, data, lat);
        expect_eq("latency ld", 64'd3, 64'(lat));
        expect_eq("rdata", ref_load(`RAM_BASE + 64'h800, ld), data);
        wdata = {32'd0, $urandom()};
        do_write(`RAM_BASE + 64'h808, wdata, lw, lat);
        ref_store(`RAM_BASE + 64'h808, wdata, lw);
        expect_eq("latency sw", 64'd2, 64'(lat));
        do_read(`RAM_BASE + 64'h808, lw, data, lat);
        expect_eq("latency lw", 64'd2, 64'(lat));
        expect_eq("rdata", ref_load(`RAM_BASE + 64'h808, lw), data);
        do_read(`PLIC_PENDING, lw, data, lat);
        expect_eq("latency plic", 64'd2, 64'(lat));
        do_read(`MTIME_ADDR, ld, data, lat);     // leaves nonzero data on rdata
        expect_eq("latency timer", 64'd2, 64'(lat));
        do_write(UNMAPPED_ADDR, {$urandom(), $urandom()}, ld, lat);
        expect_eq("latency unmapped write", 64'd2, 64'(lat));
        do_read(UNMAPPED_ADDR, ld, data, lat);
        expect_eq("latency unmapped read", 64'd2, 64'(lat));
        expect_eq("rdata", 64'd0, data);
        end_test("latency and busy rule");
    endtask

    task automatic test_timer();
        logic [63:0] t1;
        logic [63:0] t2;
        int c1;
        int lat;
        bit rose;
        do_read(`MTIME_ADDR, ld, t1, lat);
        c1 = req_cyc;
        repeat (13) @(posedge CLOCK_50);
        do_read(`MTIME_ADDR, ld, t2, lat);
        expect_eq("mtime delta", 64'(req_cyc - c1), t2 - t1);
        do_read(`MTIME_ADDR, ld, t1, lat);
        do_write(`MTIMECMP_ADDR, t1 + 64'(TIMER_LEAD), ld, lat);
        expect_eq("irq.mtip", 64'd0, 64'(irq.mtip));  // still a few cycles short
        rose = 1'b0;
        for (int i = 0; i < TIMER_LEAD && !rose; i++) begin
            @(negedge CLOCK_50);
            rose = irq.mtip;
        end
        if (!rose) begin
            $display("mtip did not rise within %0d cycles of the mtimecmp write", TIMER_LEAD);
            err_count++;
        end
        do_write(`MTIMECMP_ADDR, '1, ld, lat);
        expect_eq("irq.mtip", 64'd0, 64'(irq.mtip));
        end_test("machine timer");
    endtask

    task automatic pulse_sources(input logic [NS:1] mask);
        @(posedge CLOCK_50);
        irq_src <= mask;                      // id i sits on source bit i-1
        @(posedge CLOCK_50);
        irq_src <= '0;
        @(negedge CLOCK_50);
    endtask

    task automatic check_plic();
        logic [63:0] data;
        int lat;
        do_read(`PLIC_PENDING, lw, data, lat);
        expect_eq("pending", 64'({p_pend, 1'b0}), data);
        expect_eq("irq.meip", 64'(ref_claim(0) != 0), 64'(irq.meip));
        expect_eq("irq.seip", 64'(ref_claim(1) != 0), 64'(irq.seip));
    endtask

    task automatic test_plic();
        logic [NS:1] mask;
        logic [63:0] data;
        int exp_id;
        int lat;
        p_pend = '0;
        for (int r = 0; r < 3; r++) begin
            for (int id = 1; id <= NS; id++) begin
                p_prio[id] = PW'($urandom() % 8);
                do_write(`PLIC_BASE + 64'(4 * id), 64'(p_prio[id]), lw, lat);
            end
            for (int c = 0; c < 2; c++) begin
                p_en[c]  = NS'($urandom());
                p_thr[c] = PW'($urandom() % 4);
                do_write(`PLIC_ENABLE + 64'(c) * `PLIC_CTX_ENABLE_STRIDE,
                         64'({p_en[c], 1'b0}), lw, lat);
                do_write(`PLIC_THRESHOLD + 64'(c) * `PLIC_CTX_STRIDE, 64'(p_thr[c]), lw, lat);
            end
            mask = NS'($urandom()) | NS'(1);
            pulse_sources(mask);
            p_pend = p_pend | mask;
            check_plic();
            do_write(`PLIC_PENDING, 64'd0, lw, lat);  // pending is read only
            check_plic();
            for (int c = 0; c < 2; c++) begin
                do begin
                    exp_id = ref_claim(c);
                    do_read(`PLIC_CLAIM + 64'(c) * `PLIC_CTX_STRIDE, lw, data, lat);
                    expect_eq("claim id", 64'(exp_id), data);
                    if (exp_id != 0) p_pend[exp_id] = 1'b0;
                    check_plic();
                end while (exp_id != 0);
            end
        end
        end_test("plic claim");
    endtask

    initial begin
        void'($urandom(86168));
        read_enable  <= 1'b0;
        write_enable <= 1'b0;
        cmd          <= '0;
        irq_src      <= '0;
        KEY0         <= 1'b0;
        repeat (10) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(posedge CLOCK_50);
        test_reset();
        test_ram_widths();
        test_latency();
        test_timer();
        test_plic();
        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_ok, tests_run - tests_ok, check_count, err_count);
        if (err_count == 0) $display("Simulation passed");
        else $display("Simulation failed");
        $finish;
    end

endmodule

//--- project.f
+incdir+.
bus_pkg.sv
periph_pkg.sv
bus_fabric.sv
ram_port.sv
machine_timer.sv
plic_unit.sv
soc_periph_top.sv
tb_soc.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_soc
FILELIST  = project.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
